//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_ahb2apb
FILELIST  := sim.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/ahb2apb_bridge.sv
`timescale 1ns/100ps

module ahb2apb_bridge
  import apb_bridge_pkg::*;
(
  input  logic        i_hclk,
  input  logic        i_rst_n,
  // AHB-lite slave side
  input  logic        i_hsel,
  input  haddr_t      i_haddr,
  input  htrans_e     i_htrans,
  input  hsize_e      i_hsize,
  input  logic        i_hwrite,
  input  hdata_t      i_hwdata,
  input  logic        i_hready_in,
  output hdata_t      o_hrdata,
  output logic        o_hready,
  output hresp_e      o_hresp,
  // APB master side, shared by all slots
  output psel_t       o_psel,
  output logic        o_penable,
  output haddr_t      o_paddr,
  output logic        o_pwrite,
  output hdata_t      o_pwdata,
  output pstrb_t      o_pstrb,
  input  psel_t       i_pready,
  input  prdata_bus_t i_prdata
);

  // ------------------------------------------------------------------------
  // Stage interconnect
  // ------------------------------------------------------------------------
  logic   accept;
  logic   req_valid;
  haddr_t req_addr;
  hsize_e req_size;
  logic   req_write;
  slot_t  req_slot;
  logic   req_err;
  logic   take;
  logic   done;
  logic   done_err;
  hdata_t rdata;

  ahb_addr_stage u_addr (
    .i_hclk(i_hclk), .i_rst_n(i_rst_n), .i_hsel(i_hsel), .i_haddr(i_haddr),
    .i_htrans(i_htrans), .i_hsize(i_hsize), .i_hwrite(i_hwrite),
    .i_hready_in(i_hready_in), .i_hready(o_hready), .i_take(take),
    .o_accept(accept), .o_req_valid(req_valid), .o_req_addr(req_addr),
    .o_req_size(req_size), .o_req_write(req_write), .o_req_slot(req_slot),
    .o_req_err(req_err)
  );

  apb_access_stage u_apb (
    .i_hclk(i_hclk), .i_rst_n(i_rst_n), .i_req_valid(req_valid),
    .i_req_addr(req_addr), .i_req_size(req_size), .i_req_write(req_write),
    .i_req_slot(req_slot), .i_req_err(req_err), .i_hwdata(i_hwdata),
    .i_pready(i_pready), .i_prdata(i_prdata), .o_take(take), .o_psel(o_psel),
    .o_penable(o_penable), .o_paddr(o_paddr), .o_pwrite(o_pwrite),
    .o_pwdata(o_pwdata), .o_pstrb(o_pstrb), .o_done(done),
    .o_done_err(done_err), .o_rdata(rdata)
  );

  ahb_resp_stage u_resp (
    .i_hclk(i_hclk), .i_rst_n(i_rst_n), .i_accept(accept), .i_done(done),
    .i_done_err(done_err), .i_rdata(rdata), .o_hready(o_hready),
    .o_hresp(o_hresp), .o_hrdata(o_hrdata)
  );

endmodule

//--- hdl/ahb_addr_stage.sv
`timescale 1ns/100ps
`include "apb_bridge_settings.svh"

module ahb_addr_stage
  import apb_bridge_pkg::*;
(
  input  logic    i_hclk,
  input  logic    i_rst_n,
  input  logic    i_hsel,
  input  haddr_t  i_haddr,
  input  htrans_e i_htrans,
  input  hsize_e  i_hsize,
  input  logic    i_hwrite,
  input  logic    i_hready_in,
  input  logic    i_hready,      // Bridge's own hready
  input  logic    i_take,        // Request consumed by APB stage
  output logic    o_accept,      // Address phase accepted this edge
  output logic    o_req_valid,
  output haddr_t  o_req_addr,
  output hsize_e  o_req_size,
  output logic    o_req_write,
  output slot_t   o_req_slot,
  output logic    o_req_err      // Unmapped or unpopulated
);

  // Bits at and above DEC_LSB must match the base
  localparam int     DEC_LSB   = `APB_SLOT_BITS + $bits(slot_t);
  localparam haddr_t BASE_ADDR = `APB_BASE_ADDR;
  localparam logic [15:0] SLOT_MASK = 16'(`APB_SLOT_MASK); // Unused slot codes read 0

  logic  in_window;
  logic  slot_ok;
  slot_t slot;

  // ------------------------------------------------------------------------
  // Acceptance and decode
  // ------------------------------------------------------------------------

  assign o_accept = i_hsel && i_hready_in && i_hready &&
                    ((i_htrans == NONSEQ) || (i_htrans == SEQ));  // IDLE, BUSY ignored

  assign slot      = i_haddr[`APB_SLOT_BITS +: $bits(slot_t)];
  assign in_window = (i_haddr[31:DEC_LSB] == BASE_ADDR[31:DEC_LSB]);
  assign slot_ok   = (slot < slot_t'(`APB_NUM_SLAVES)) && SLOT_MASK[slot];

  // Request holding register
  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_req_valid <= 1'b0;
    end else if (o_accept) begin
      o_req_valid <= 1'b1;
    end else if (i_take) begin
      o_req_valid <= 1'b0;   // Handed to APB stage
    end
  end

  // Request payload
  always_ff @(posedge i_hclk) begin
    if (o_accept) begin
      o_req_addr  <= i_haddr;
      o_req_size  <= i_hsize;
      o_req_write <= i_hwrite;
      o_req_slot  <= slot;
      o_req_err   <= !(in_window && slot_ok);
    end
  end

  // AHB-lite holds the next address while hready is low, so only one request
  a_single_request : assert property (
    @(posedge i_hclk) disable iff (!i_rst_n)
    o_req_valid |-> !o_accept
  );

endmodule

//--- hdl/ahb_resp_stage.sv
`timescale 1ns/100ps

module ahb_resp_stage
  import apb_bridge_pkg::*;
(
  input  logic   i_hclk,
  input  logic   i_rst_n,
  input  logic   i_accept,    // Address phase taken
  input  logic   i_done,      // Transfer finished
  input  logic   i_done_err,
  input  hdata_t i_rdata,     // Active slot's prdata
  output logic   o_hready,
  output hresp_e o_hresp,
  output hdata_t o_hrdata
);

  logic err_second;   // Second ERROR cycle with hready high

  // ------------------------------------------------------------------------
  // hready sequencing
  // ------------------------------------------------------------------------

  // Low from accept until one edge after done
  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_hready   <= 1'b1;
      err_second <= 1'b0;
    end else begin
      if (i_accept) begin
        o_hready <= 1'b0;
      end else if (i_done) begin
        o_hready <= 1'b1;
      end
      err_second <= i_done && i_done_err;
    end
  end

  // First ERROR cycle rides on done_err and the second on err_second
  assign o_hresp = (i_done_err || err_second) ? ERROR : OKAY;

  // Read data captured at APB completion
  always_ff @(posedge i_hclk) begin
    if (i_done && !i_done_err) begin
      o_hrdata <= i_rdata;
    end
  end

  // Two-cycle ERROR with hready low then high
  a_err_first_low : assert property (
    @(posedge i_hclk) disable iff (!i_rst_n)
    (o_hresp == ERROR && !err_second) |-> !o_hready
  );
  a_err_second_high : assert property (
    @(posedge i_hclk) disable iff (!i_rst_n)
    err_second |-> o_hready
  );

endmodule

//--- hdl/apb_access_stage.sv
`timescale 1ns/100ps
`include "apb_bridge_settings.svh"

module apb_access_stage
  import apb_bridge_pkg::*;
(
  input  logic        i_hclk,
  input  logic        i_rst_n,
  input  logic        i_req_valid,
  input  haddr_t      i_req_addr,
  input  hsize_e      i_req_size,
  input  logic        i_req_write,
  input  slot_t       i_req_slot,
  input  logic        i_req_err,
  input  hdata_t      i_hwdata,    // AHB data phase
  input  psel_t       i_pready,
  input  prdata_bus_t i_prdata,
  output logic        o_take,
  output psel_t       o_psel,
  output logic        o_penable,
  output haddr_t      o_paddr,
  output logic        o_pwrite,
  output hdata_t      o_pwdata,
  output pstrb_t      o_pstrb,
  output logic        o_done,      // Transfer complete, one cycle
  output logic        o_done_err,  // Completion is an error
  output hdata_t      o_rdata
);

  apb_state_e state;
  logic       err_done;     // Error request finished without APB
  logic       pready_sel;   // pready of the active slot

  // Byte lanes from size and low address bits
  function automatic pstrb_t strb_calc(input hsize_e size, input logic [1:0] lsb);
    pstrb_t strb;
    case (size)
      BYTE:    strb = pstrb_t'(4'b0001 << lsb);
      HALF:    strb = lsb[1] ? 4'b1100 : 4'b0011;
      default: strb = 4'b1111;
    endcase
    if (`SYSTEM_BIG_ENDIAN != 0) begin
      strb = {strb[0], strb[1], strb[2], strb[3]};  // Lane n to lane 3-n
    end
    return strb;
  endfunction

  // ------------------------------------------------------------------------
  // Slot response mux
  // ------------------------------------------------------------------------

  // AND-OR select on the one-hot psel
  always_comb begin
    pready_sel = 1'b0;
    o_rdata    = '0;
    for (int s = 0; s < `APB_NUM_SLAVES; s++) begin
      pready_sel = pready_sel | (o_psel[s] & i_pready[s]);
      o_rdata    = o_rdata | ({32{o_psel[s]}} & i_prdata[s*32 +: 32]);
    end
  end

  assign o_take     = i_req_valid && (state == APB_IDLE);
  assign o_penable  = (state == APB_ACCESS);
  assign o_done     = (o_penable && pready_sel) || err_done;
  assign o_done_err = err_done;

  // ------------------------------------------------------------------------
  // APB phase FSM
  // ------------------------------------------------------------------------

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= APB_IDLE;
      o_psel   <= '0;
      err_done <= 1'b0;
    end else begin
      err_done <= o_take && i_req_err;   // Skip APB, finish next cycle
      case (state)
        APB_IDLE: begin
          if (o_take && !i_req_err) begin
            state  <= APB_SETUP;
            o_psel <= psel_t'(1) << i_req_slot;
          end
        end
        APB_SETUP: state <= APB_ACCESS;
        APB_ACCESS: begin
          if (pready_sel) begin       // Wait states stretch this phase
            state  <= APB_IDLE;
            o_psel <= '0;
          end
        end
        default: state <= APB_IDLE;
      endcase
    end
  end

  // Address, control and write data held for the whole transfer
  always_ff @(posedge i_hclk) begin
    if (o_take) begin
      o_paddr  <= i_req_addr;
      o_pwrite <= i_req_write;
      o_pwdata <= i_hwdata;   // Data phase is the take cycle
      o_pstrb  <= strb_calc(i_req_size, i_req_addr[1:0]);
    end
  end

  a_penable_psel : assert property (
    @(posedge i_hclk) disable iff (!i_rst_n) o_penable |-> (o_psel != '0));
  a_psel_onehot : assert property (
    @(posedge i_hclk) disable iff (!i_rst_n) $onehot0(o_psel));
  a_access_stable : assert property (
    @(posedge i_hclk) disable iff (!i_rst_n)
    o_penable |-> ($stable(o_paddr) && $stable(o_pwrite) && $stable(o_pwdata)));

endmodule

//--- hdl/apb_bridge_pkg.sv
`include "apb_bridge_settings.svh"

package apb_bridge_pkg;

  // Bus widths
  typedef logic [31:0] haddr_t;                        // AHB/APB address
  typedef logic [31:0] hdata_t;                        // Data bus
  typedef logic [3:0]  slot_t;                         // Slot index, haddr[19:16]
  typedef logic [`APB_NUM_SLAVES-1:0] psel_t;          // One-hot slave select
  typedef logic [3:0]  pstrb_t;                        // Byte-lane strobes
  typedef logic [`APB_NUM_SLAVES*32-1:0] prdata_bus_t; // Slot n read data at [32n +: 32]

  // AHB transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // AHB transfer size, wider sizes not supported on a 32-bit bus
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // AHB-lite response
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

  // APB phase sequencer
  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,
    APB_ACCESS = 2'b10
  } apb_state_e;

endpackage

//--- hdl/apb_bridge_settings.svh
`ifndef APB_BRIDGE_SETTINGS_SVH
`define APB_BRIDGE_SETTINGS_SVH

// ------------------------------------------------------------------------
// APB peripheral address map
// ------------------------------------------------------------------------

// Nine 64 KB slots from 0x0080_0000 up to 0x0088_FFFF
`define APB_NUM_SLAVES  9
`define APB_BASE_ADDR   32'h0080_0000  // Slot 0 base
`define APB_SLOT_BITS   16             // log2 of slot size

// Populated slots, bit n for slot n
// Slots 4 and 7 have no peripheral and answer with ERROR
`define APB_SLOT_MASK   9'b1_0110_1111

// ------------------------------------------------------------------------
// Byte-lane order
// ------------------------------------------------------------------------

// 0 for little endian, 1 reverses the byte lanes (lane n to lane 3-n)
`define SYSTEM_BIG_ENDIAN 0

`endif

//--- sim.f
+incdir+hdl
hdl/apb_bridge_pkg.sv
hdl/ahb_addr_stage.sv
hdl/apb_access_stage.sv
hdl/ahb_resp_stage.sv
hdl/ahb2apb_bridge.sv
testbench/bridge_checker.sv
testbench/tb_ahb2apb.sv

//--- testbench/bridge_checker.sv
`timescale 1ns/100ps
`include "apb_bridge_settings.svh"

module bridge_checker
  import apb_bridge_pkg::*;
(
  input  logic    i_hclk,
  input  logic    i_rst_n,
  input  logic    i_hsel,
  input  haddr_t  i_haddr,
  input  htrans_e i_htrans,
  input  hsize_e  i_hsize,
  input  logic    i_hwrite,
  input  hdata_t  i_hwdata,
  input  logic    i_hready_in,
  input  hdata_t  i_hrdata,      // DUT outputs from here on
  input  logic    i_hready,
  input  hresp_e  i_hresp,
  input  psel_t   i_psel,
  input  logic    i_penable,
  input  haddr_t  i_paddr,
  input  logic    i_pwrite,
  input  hdata_t  i_pwdata,
  input  pstrb_t  i_pstrb,
  output int      o_errors,
  output int      o_completed    // Transfers seen through their response
);

  localparam haddr_t      BASE      = `APB_BASE_ADDR;
  localparam logic [15:0] POPULATED = 16'(`APB_SLOT_MASK);

  logic [7:0] mem [0:`APB_NUM_SLAVES-1][0:63];   // Expected slot contents
  logic   busy;         // Accepted, response not seen yet
  logic   got_data;     // Data phase sampled
  logic   saw_psel;
  logic   err_first;    // ERROR with hready low seen
  logic   prev_psel;
  logic   exp_err;
  logic   exp_write;
  haddr_t exp_addr;
  hdata_t exp_wdata;
  psel_t  exp_psel;
  pstrb_t exp_strb;
  slot_t  slot;

  // Same power-on pattern as the slot models
  function automatic logic [7:0] power_on_byte(input int s, input int b);
    return 8'((s * 64 + b) * 29 + 90);
  endfunction

  // Lane n is enabled when its byte falls inside the transfer
  function automatic pstrb_t lanes_for(input hsize_e size, input logic [1:0] lsb);
    pstrb_t m;
    for (int n = 0; n < 4; n++) begin
      case (size)
        BYTE:    m[n] = (n == int'(lsb));
        HALF:    m[n] = ((n / 2) == int'(lsb[1]));
        default: m[n] = 1'b1;
      endcase
    end
    if (`SYSTEM_BIG_ENDIAN != 0) begin
      m = {m[0], m[1], m[2], m[3]};   // Mirror lanes
    end
    return m;
  endfunction

  function automatic hdata_t model_word(input slot_t s, input haddr_t a);
    int o;
    o = int'(a[5:2]) * 4;
    return {mem[s][o+3], mem[s][o+2], mem[s][o+1], mem[s][o]};
  endfunction

  task automatic bad_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch at %0t ns: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
    o_errors++;
  endtask

  task automatic fault(input string what);
    $display("Error at %0t ns: %s", $time, what);
    o_errors++;
  endtask

  // ------------------------------------------------------------------------
  // Monitor, all values sampled just before the rising edge
  // ------------------------------------------------------------------------
  always @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_errors    = 0;
      o_completed = 0;
      busy        = 1'b0;
      prev_psel   = 1'b0;
      for (int s = 0; s < `APB_NUM_SLAVES; s++) begin
        for (int b = 0; b < 64; b++) begin
          mem[s][b] = power_on_byte(s, b);
        end
      end
    end else begin
      // Write data arrives one cycle after the address
      if (busy && !got_data) begin
        exp_wdata = i_hwdata;
        got_data  = 1'b1;
        if (exp_write && !exp_err) begin
          for (int n = 0; n < 4; n++) begin
            if (exp_strb[n]) mem[slot][int'(exp_addr[5:2]) * 4 + n] = exp_wdata[8*n +: 8];
          end
        end
      end

      // APB side
      if (i_penable && i_psel == '0) fault("penable high with no psel");
      if (i_penable && !prev_psel) fault("access phase entered without a setup phase");
      if (i_psel != '0) begin
        saw_psel = 1'b1;
        if (i_hready) fault("hready high while an APB transfer is running");
        if (!busy || exp_err) begin
          fault("psel raised with no mapped transfer pending");
        end else begin
          if (i_psel != exp_psel) bad_value("o_psel", 32'(i_psel), 32'(exp_psel));
          if (i_paddr != exp_addr) bad_value("o_paddr", i_paddr, exp_addr);
          if (i_pwrite != exp_write) bad_value("o_pwrite", 32'(i_pwrite), 32'(exp_write));
          if (i_pstrb != exp_strb) bad_value("o_pstrb", 32'(i_pstrb), 32'(exp_strb));
          if (exp_write && i_pwdata != exp_wdata) bad_value("o_pwdata", i_pwdata, exp_wdata);
        end
      end
      prev_psel = (i_psel != '0);

      // AHB response
      if (busy) begin
        if (!i_hready) begin
          if (i_hresp == ERROR) begin
            if (!exp_err) fault("ERROR response to a mapped transfer");
            err_first = 1'b1;
          end
        end else begin
          o_completed++;
          busy = 1'b0;
          if (exp_err) begin
            if (i_hresp != ERROR || !err_first)
              fault("unmapped transfer did not end in a two-cycle ERROR response");
          end else begin
            if (i_hresp != OKAY) bad_value("o_hresp", 32'(i_hresp), 32'(OKAY));
            if (!saw_psel) fault("mapped transfer completed without an APB cycle");
            if (!exp_write && i_hrdata != model_word(slot, exp_addr))
              bad_value("o_hrdata", i_hrdata, model_word(slot, exp_addr));
          end
        end
      end else if (!i_hready) begin
        fault("hready low with no transfer pending");
      end

      // New address phase
      if (i_hsel && i_hready_in && i_hready && (i_htrans == NONSEQ || i_htrans == SEQ)) begin
        slot      = i_haddr[19:16];
        exp_addr  = i_haddr;
        exp_write = i_hwrite;
        exp_strb  = lanes_for(i_hsize, i_haddr[1:0]);
        exp_err   = (i_haddr[31:20] != BASE[31:20]) ||
                    (int'(slot) >= `APB_NUM_SLAVES) || !POPULATED[slot];
        exp_psel  = '0;
        if (!exp_err) exp_psel[slot] = 1'b1;   // One-hot from haddr[19:16]
        busy      = 1'b1;
        got_data  = 1'b0;
        saw_psel  = 1'b0;
        err_first = 1'b0;
      end
    end
  end

endmodule

//--- testbench/tb_ahb2apb.sv
`timescale 1ns/100ps
`include "apb_bridge_settings.svh"

module tb_ahb2apb
  import apb_bridge_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_XFERS   = 400;
  localparam int WATCHDOG_NS = NUM_XFERS * 12 * CLK_PERIOD;  // 12 cycles per transfer, worst case

  logic        hclk      = 1'b0;
  logic        rst_n     = 1'b0;
  logic        hsel      = 1'b0;
  haddr_t      haddr     = '0;
  htrans_e     htrans    = IDLE;
  hsize_e      hsize     = BYTE;
  logic        hwrite    = 1'b0;
  hdata_t      hwdata    = '0;
  logic        hready_in = 1'b1;
  psel_t       pready    = '0;
  prdata_bus_t prdata    = '0;
  hdata_t      hrdata;
  logic        hready;
  hresp_e      hresp;
  psel_t       psel;
  logic        penable;
  haddr_t      paddr;
  logic        pwrite;
  hdata_t      pwdata;
  pstrb_t      pstrb;

  int seed = 96;
  int wait_left;        // Wait states left in the running access
  int errors;
  int completed;
  logic [7:0] slave_mem [0:`APB_NUM_SLAVES-1][0:63];

  ahb2apb_bridge dut0 (
    .i_hclk(hclk), .i_rst_n(rst_n), .i_hsel(hsel), .i_haddr(haddr), .i_htrans(htrans),
    .i_hsize(hsize), .i_hwrite(hwrite), .i_hwdata(hwdata), .i_hready_in(hready_in),
    .o_hrdata(hrdata), .o_hready(hready), .o_hresp(hresp), .o_psel(psel),
    .o_penable(penable), .o_paddr(paddr), .o_pwrite(pwrite), .o_pwdata(pwdata),
    .o_pstrb(pstrb), .i_pready(pready), .i_prdata(prdata)
  );

  bridge_checker chk0 (
    .i_hclk(hclk), .i_rst_n(rst_n), .i_hsel(hsel), .i_haddr(haddr), .i_htrans(htrans),
    .i_hsize(hsize), .i_hwrite(hwrite), .i_hwdata(hwdata), .i_hready_in(hready_in),
    .i_hrdata(hrdata), .i_hready(hready), .i_hresp(hresp), .i_psel(psel),
    .i_penable(penable), .i_paddr(paddr), .i_pwrite(pwrite), .i_pwdata(pwdata),
    .i_pstrb(pstrb), .o_errors(errors), .o_completed(completed)
  );

  initial begin
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  function automatic logic [7:0] power_on_byte(input int s, input int b);
    return 8'((s * 64 + b) * 29 + 90);
  endfunction

  function automatic hsize_e pick_size();
    case ($unsigned($random(seed)) % 3)
      0:       return BYTE;
      1:       return HALF;
      default: return WORD;
    endcase
  endfunction

  // Mostly inside the map, slots 9 and 10 and 1 in 16 anywhere
  function automatic haddr_t pick_addr(input hsize_e size);
    haddr_t a;
    int     slot;
    slot = $unsigned($random(seed)) % 11;
    a    = `APB_BASE_ADDR + haddr_t'(slot << `APB_SLOT_BITS) + ($unsigned($random(seed)) % 64);
    if (($unsigned($random(seed)) % 16) == 0) a = $random(seed);
    if (size == HALF) a[0] = 1'b0;
    if (size == WORD) a[1:0] = 2'b00;
    return a;
  endfunction

  // Cycles that must not start a transfer
  task automatic idle_gap(input int cycles);
    int kind;
    for (int c = 0; c < cycles; c++) begin
      kind = $unsigned($random(seed)) % 4;
      hsel      <= (kind != 2);
      htrans    <= (kind == 0) ? IDLE : (kind == 1) ? BUSY : NONSEQ;
      hready_in <= (kind != 3);
      hwrite    <= 1'($random(seed));
      haddr     <= pick_addr(WORD);
      @(posedge hclk);
    end
  endtask

  task automatic run_transfer(input haddr_t addr, input hsize_e size, input logic write,
                              input hdata_t data);
    hsel      <= 1'b1;
    hready_in <= 1'b1;
    haddr     <= addr;
    hsize     <= size;
    hwrite    <= write;
    htrans    <= (($random(seed) & 1) != 0) ? SEQ : NONSEQ;
    @(posedge hclk);                   // Accepted, bridge hready is high here
    hsel   <= 1'b0;
    htrans <= IDLE;
    hwdata <= data;                    // Data phase
    do begin
      @(posedge hclk);
    end while (!hready);
  endtask

  // ------------------------------------------------------------------------
  // APB slot models, only the selected one answers
  // ------------------------------------------------------------------------
  always @(posedge hclk) begin
    int word_off;
    if (!rst_n) begin
      for (int s = 0; s < `APB_NUM_SLAVES; s++) begin
        for (int b = 0; b < 64; b++) begin
          slave_mem[s][b] <= power_on_byte(s, b);
        end
      end
    end else begin
      word_off = int'(paddr[5:2]) * 4;
      for (int s = 0; s < `APB_NUM_SLAVES; s++) begin
        if (psel[s] && !penable) begin       // Setup, pick 0 to 3 waits
          wait_left = $unsigned($random(seed)) % 4;
          pready[s] <= (wait_left == 0);
          prdata[s*32 +: 32] <= {slave_mem[s][word_off+3], slave_mem[s][word_off+2],
                                 slave_mem[s][word_off+1], slave_mem[s][word_off]};
        end else if (psel[s] && penable) begin
          if (pready[s]) begin               // Completes at this edge
            pready[s] <= 1'b0;
            for (int k = 0; k < 4; k++) begin
              if (pwrite && pstrb[k]) slave_mem[s][word_off+k] <= pwdata[8*k +: 8];
            end
          end else begin
            wait_left = wait_left - 1;
            pready[s] <= (wait_left == 0);
          end
        end
      end
    end
  end

  initial begin
    haddr_t addr;
    hsize_e size;
    logic   write;
    logic   readback;      // Read the last write back
    int     lost;
    readback = 1'b0;
    lost     = 0;
    repeat (2) @(posedge hclk);
    rst_n <= 1'b1;
    @(posedge hclk);
    for (int n = 0; n < NUM_XFERS; n++) begin
      idle_gap($unsigned($random(seed)) % 3);
      if (readback) begin
        write = 1'b0;      // Same address and size
      end else begin
        size  = pick_size();
        addr  = pick_addr(size);
        write = 1'($random(seed));
      end
      run_transfer(addr, size, write, $random(seed));
      readback = write && (($random(seed) & 1) != 0);
    end
    repeat (4) @(posedge hclk);
    if (completed != NUM_XFERS) begin
      $display("Error: only %0d of %0d transfers got a response", completed, NUM_XFERS);
      lost = 1;
    end
    $display("Done: %0d transfers, %0d errors", completed, errors + lost);
    if (errors + lost == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule
